// File: build.f
hw/boot_pkg.sv
hw/spi_master.sv
hw/uart_tx.sv
hw/flash_streamer.sv
hw/boot_stream_top.sv
tests/stream_assertions.sv
tests/stream_checker.sv
tests/tb_sopc.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the boot stream testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -j 0 --top-module tb_sopc -f build.f \
   -o tb_sopc_sim > build.log 2>&1 \
   && ./obj_dir/tb_sopc_sim +verilator+error+limit+1000 > sim.log 2>&1
grep -qx "STATUS: PASS" sim.log 2>/dev/null \
   && echo "Simulation passed" \
   || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// File: tests/tb_sopc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sopc import boot_pkg::*; ();

   localparam int AW       = 8 * ADDR_BYTES;
   localparam int HDR_BITS = 8 * (ADDR_BYTES + 1);   // Opcode plus address

   logic      clk      = 1'b0;
   logic      arst_n   = 1'b0;
   logic      start    = 1'b0;
   boot_req_t req      = '0;
   logic      spi_miso = 1'b0;
   logic      busy;
   logic      done;
   logic      spi_sck;
   logic      spi_cs_l;
   logic      spi_mosi;
   logic      uart_txd;

   boot_req_t     cur_req      = '0;   // Request the flash expects to see
   int            tb_errors    = 0;
   int            flash_errors = 0;
   int            rise_cnt     = 0;
   logic [7:0]    in_byte      = '0;
   logic [7:0]    out_byte     = '0;
   logic [AW-1:0] flash_addr   = '0;

   always #2 clk = ~clk;

   boot_stream_top #(.sck_half(DEF_SCK_HALF), .clks_per_bit(DEF_CLKS_PER_BIT)) UUT (.*);

   stream_checker #(.clks_per_bit(DEF_CLKS_PER_BIT)) mon (.*);

   // Flash array contents
   function automatic logic [7:0] flash_byte(input logic [AW-1:0] a);
      return a[7:0] ^ a[15:8] ^ 8'h5A;
   endfunction

   // Flash model, shifts mosi in on each SCK rise
   always @(posedge spi_sck or posedge spi_cs_l) begin
      if (spi_cs_l) begin
         rise_cnt = 0;
      end else begin
         in_byte  = {in_byte[6:0], spi_mosi};
         rise_cnt = rise_cnt + 1;
         if (rise_cnt == 8 && in_byte != FLASH_READ_CMD) begin
            flash_errors++;
            $display("Fail at %0t: spi_mosi opcode expected %02h got %02h",
                     $time, FLASH_READ_CMD, in_byte);
         end else if (rise_cnt > 8 && rise_cnt <= HDR_BITS && rise_cnt % 8 == 0) begin
            flash_addr = {flash_addr[AW-9:0], in_byte};   // MSB first
         end
         if (rise_cnt == HDR_BITS && flash_addr != cur_req.addr) begin
            flash_errors++;
            $display("Fail at %0t: spi_mosi address expected %06h got %06h",
                     $time, cur_req.addr, flash_addr);
         end
         if (rise_cnt >= HDR_BITS && rise_cnt % 8 == 0) begin
            out_byte   = flash_byte(flash_addr);
            flash_addr = flash_addr + AW'(1);   // Wraps at 24 bits
         end
      end
   end

   always @(negedge spi_sck) begin
      if (rise_cnt >= HDR_BITS)
         spi_miso = out_byte[7 - ((rise_cnt - HDR_BITS) % 8)];
   end

   task automatic check_level(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         tb_errors++;
         $display("Fail at %0t: %s expected %b got %b", $time, name, exp, got);
      end
   endtask

   task automatic close_run;
      int total;
      total = tb_errors + flash_errors + mon.errors + UUT.port_props.fails;
      $display("Errors: testbench %0d, flash %0d, checker %0d, assertions %0d",
               tb_errors, flash_errors, mon.errors, UUT.port_props.fails);
      if (total == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   endtask

   task automatic wait_done(input int limit);
      int n;
      n = 0;
      while (!done && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (!done) begin
         tb_errors++;
         $display("Timeout: done did not pulse within %0d cycles", limit);
         close_run();
      end
   endtask

   task automatic pulse_start(input boot_req_t r);
      @(negedge clk);
      req   = r;
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
   endtask

   task automatic run_request(input logic [AW-1:0] addr, input logic [7:0] len);
      int n_bytes;
      n_bytes = (len == 8'd0) ? 256 : int'(len);
      cur_req = {addr, len};
      pulse_start(cur_req);
      wait_done(200 * (n_bytes + ADDR_BYTES + 1));
   endtask

   // Second strobe lands mid transfer and must be dropped
   task automatic check_start_while_busy;
      cur_req = {24'h00F0F0, 8'd3};
      pulse_start(cur_req);
      check_level("busy", busy, 1'b1);
      repeat (20) @(negedge clk);
      pulse_start({24'h777777, 8'd9});
      wait_done(200 * 8);
      repeat (30 * DEF_CLKS_PER_BIT) @(negedge clk);   // Room for a stray frame
   endtask

   initial begin
      logic [AW-1:0] addr;
      void'($urandom(19276));
      repeat (8) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      check_level("spi_cs_l", spi_cs_l, 1'b1);
      check_level("uart_txd", uart_txd, 1'b1);
      check_level("busy", busy, 1'b0);
      check_level("done", done, 1'b0);
      run_request(24'h000100, 8'd1);
      run_request(24'h012345, 8'd5);
      run_request(24'hABCDEF, 8'd0);   // 256 bytes
      run_request(24'hFFFFFE, 8'd4);
      check_start_while_busy();
      for (int i = 0; i < 20; i++) begin
         if ($urandom % 3 == 0)
            addr = 24'hFFFFFF - AW'($urandom % 8);   // Near the wrap
         else
            addr = AW'($urandom);
         run_request(addr, 8'($urandom));
      end
      close_run();
   end

endmodule

`default_nettype wire

// File: tests/stream_checker.sv
`timescale 1ns/1ps
`default_nettype none

module stream_checker import boot_pkg::*; #(
   parameter int clks_per_bit = DEF_CLKS_PER_BIT
) (
   input logic      clk,
   input logic      arst_n,
   input logic      start,
   input boot_req_t req,
   input logic      busy,
   input logic      done,
   input logic      uart_txd
);

   localparam int AW = 8 * ADDR_BYTES;

   int            errors   = 0;
   logic          active   = 1'b0;   // Between accepted start and done
   logic [AW-1:0] exp_addr = '0;
   int            exp_left = 0;
   logic          in_frame = 1'b0;
   int            tick     = 0;
   logic [9:0]    frame    = '0;

   // Expected byte for a flash address
   function automatic logic [7:0] data_at(input logic [AW-1:0] a);
      return a[7:0] ^ a[15:8] ^ 8'h5A;
   endfunction

   task automatic check_frame(input logic [9:0] f);
      if (f[0] !== 1'b0 || f[9] !== 1'b1) begin
         errors++;
         $display("Fail at %0t: uart_txd start/stop expected 0/1 got %b/%b",
                  $time, f[0], f[9]);
      end
      if (exp_left == 0) begin
         errors++;
         $display("UART sent byte %02h at %0t with no byte left to send", f[8:1], $time);
      end else begin
         if (f[8:1] !== data_at(exp_addr)) begin
            errors++;
            $display("Fail at %0t: uart_txd byte expected %02h got %02h",
                     $time, data_at(exp_addr), f[8:1]);
         end
         exp_addr = exp_addr + AW'(1);
         exp_left = exp_left - 1;
      end
   endtask

   always @(posedge clk) begin
      if (arst_n) begin
         if (!in_frame) begin
            if (!uart_txd) begin
               in_frame = 1'b1;   // Start bit edge
               tick     = 0;
            end
         end else begin
            tick = tick + 1;
            if (tick % clks_per_bit == clks_per_bit / 2) begin   // Mid bit
               frame = {uart_txd, frame[9:1]};
               if (tick / clks_per_bit == 9) begin
                  in_frame = 1'b0;
                  check_frame(frame);
               end
            end
         end

         if (done) begin
            if (!active) begin
               errors++;
               $display("done pulsed at %0t with no request in progress", $time);
            end else if (exp_left != 0) begin
               errors++;
               $display("done pulsed at %0t with %0d bytes still missing", $time, exp_left);
            end
            active = 1'b0;
         end else if (active && !busy) begin
            errors++;
            $display("busy fell at %0t before done pulsed", $time);
            active = 1'b0;
         end

         if (start && !busy) begin
            active   = 1'b1;
            exp_addr = req.addr;
            exp_left = (req.len == 8'd0) ? 256 : int'(req.len);
         end
      end
   end

endmodule

`default_nettype wire

// File: tests/stream_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module stream_assertions (
   input logic clk,
   input logic arst_n,
   input logic busy,
   input logic done,
   input logic spi_sck,
   input logic spi_cs_l
);

   int fails = 0;

   // Flash deselected whenever the streamer is idle
   cs_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
      !busy |-> spi_cs_l)
      else begin
         fails++;
         $error("spi_cs_l low while busy is low");
      end

   done_single: assert property (@(posedge clk) disable iff (!arst_n)
      done |=> !done)
      else begin
         fails++;
         $error("done held high for more than one cycle");
      end

   // No clock edges toward a deselected flash
   sck_in_frame: assert property (@(posedge clk) disable iff (!arst_n)
      (spi_sck != $past(spi_sck)) |-> !spi_cs_l)
      else begin
         fails++;
         $error("spi_sck toggled while spi_cs_l is high");
      end

endmodule

bind boot_stream_top stream_assertions port_props (
   .clk, .arst_n, .busy, .done, .spi_sck, .spi_cs_l
);

`default_nettype wire

// File: hw/boot_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

module boot_stream_top import boot_pkg::*; #(
   parameter int sck_half     = DEF_SCK_HALF,
   parameter int clks_per_bit = DEF_CLKS_PER_BIT
) (
   input  logic      clk,
   input  logic      arst_n,
   input  logic      start,
   input  boot_req_t req,
   output logic      busy,
   output logic      done,
   output logic      spi_sck,
   output logic      spi_cs_l,
   output logic      spi_mosi,
   input  logic      spi_miso,
   output logic      uart_txd
);

   logic       spi_go;
   logic [7:0] spi_tx;
   logic       spi_done;
   logic [7:0] spi_rx;
   logic       tx_go;
   logic [7:0] tx_byte;
   logic       tx_busy;

   flash_streamer streamer (
      .clk      (clk),
      .arst_n   (arst_n),
      .start    (start),
      .req      (req),
      .busy     (busy),
      .done     (done),
      .spi_cs_l (spi_cs_l),
      .spi_go   (spi_go),
      .spi_tx   (spi_tx),
      .spi_done (spi_done),
      .spi_rx   (spi_rx),
      .tx_go    (tx_go),
      .tx_byte  (tx_byte),
      .tx_busy  (tx_busy)
   );

   spi_master #(
      .sck_half (sck_half)
   ) spi (
      .clk        (clk),
      .arst_n     (arst_n),
      .go         (spi_go),
      .tx         (spi_tx),
      .busy       (),   // Streamer tracks its own byte in flight
      .done_pulse (spi_done),
      .rx         (spi_rx),
      .sck        (spi_sck),
      .mosi       (spi_mosi),
      .miso       (spi_miso)
   );

   uart_tx #(
      .clks_per_bit (clks_per_bit)
   ) uart (
      .clk    (clk),
      .arst_n (arst_n),
      .go     (tx_go),
      .data   (tx_byte),
      .busy   (tx_busy),
      .txd    (uart_txd)
   );

endmodule

`default_nettype wire

// File: hw/flash_streamer.sv
`timescale 1ns/1ps
`default_nettype none

module flash_streamer import boot_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       start,
   input  boot_req_t  req,
   output logic       busy,
   output logic       done,
   output logic       spi_cs_l,
   output logic       spi_go,
   output logic [7:0] spi_tx,
   input  logic       spi_done,
   input  logic [7:0] spi_rx,
   output logic       tx_go,
   output logic [7:0] tx_byte,
   input  logic       tx_busy
);

   localparam int AW = 8 * ADDR_BYTES;
   localparam int IW = (ADDR_BYTES > 1) ? $clog2(ADDR_BYTES) : 1;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_CMD,
      ST_ADDR,
      ST_DATA,
      ST_DRAIN
   } state_t;

   state_t        state;
   logic [AW-1:0] addr_sh;     // Top byte goes out next
   logic [IW-1:0] addr_idx;
   logic [8:0]    remaining;   // 1 to 256 bytes
   logic          spi_pend;    // SPI byte in flight
   logic          buf_full;
   logic [7:0]    buf_byte;

   assign busy    = (state != ST_IDLE);
   assign tx_go   = buf_full && !tx_busy;
   assign tx_byte = buf_byte;

   // Next SPI byte, one at a time
   always_comb begin
      spi_go = 1'b0;
      spi_tx = 8'h00;   // Dummy byte during data phase
      if (!spi_pend) begin
         case (state)
            ST_CMD: begin
               spi_go = 1'b1;
               spi_tx = FLASH_READ_CMD;
            end
            ST_ADDR: begin
               spi_go = 1'b1;
               spi_tx = addr_sh[AW-1 -: 8];
            end
            ST_DATA: spi_go = !buf_full;   // Hold off while UART is behind
            default: spi_go = 1'b0;
         endcase
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= ST_IDLE;
         spi_cs_l  <= 1'b1;
         addr_idx  <= '0;
         remaining <= '0;
         spi_pend  <= 1'b0;
         buf_full  <= 1'b0;
         done      <= 1'b0;
      end else begin
         done <= 1'b0;
         if (spi_go)
            spi_pend <= 1'b1;
         else if (spi_done)
            spi_pend <= 1'b0;
         if (tx_go)
            buf_full <= 1'b0;

         case (state)
            ST_IDLE: begin
               if (start) begin
                  state     <= ST_CMD;
                  spi_cs_l  <= 1'b0;
                  addr_idx  <= '0;
                  remaining <= (req.len == 8'd0) ? 9'd256 : {1'b0, req.len};
               end
            end
            ST_CMD: begin
               if (spi_done)
                  state <= ST_ADDR;
            end
            ST_ADDR: begin
               if (spi_done) begin
                  addr_idx <= addr_idx + 1'b1;
                  if (addr_idx == IW'(ADDR_BYTES - 1))
                     state <= ST_DATA;
               end
            end
            ST_DATA: begin
               if (spi_done) begin
                  buf_full  <= 1'b1;
                  remaining <= remaining - 9'd1;
                  if (remaining == 9'd1) begin
                     spi_cs_l <= 1'b1;   // Last byte in, release flash
                     state    <= ST_DRAIN;
                  end
               end
            end
            ST_DRAIN: begin
               // Wait for the last frame to clear the wire
               if (!buf_full && !tx_busy) begin
                  done  <= 1'b1;
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_IDLE && start)
         addr_sh <= req.addr;
      else if (state == ST_ADDR && spi_done)
         addr_sh <= addr_sh << 8;
      if (state == ST_DATA && spi_done)
         buf_byte <= spi_rx;
   end

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx import boot_pkg::*; #(
   parameter int clks_per_bit = DEF_CLKS_PER_BIT
) (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       go,
   input  logic [7:0] data,
   output logic       busy,
   output logic       txd
);

   localparam int CW = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

   logic [CW-1:0] bit_cnt;
   logic [3:0]    bit_idx;   // 0 is the start bit, 9 the stop bit
   logic [9:0]    frame;

   // Frame fills with ones as it shifts, so the line rests at mark
   assign txd = frame[0];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy    <= 1'b0;
         frame   <= '1;
         bit_cnt <= '0;
         bit_idx <= '0;
      end else if (!busy) begin
         if (go) begin
            busy    <= 1'b1;
            frame   <= {1'b1, data, 1'b0};   // Stop, data LSB first, start
            bit_cnt <= '0;
            bit_idx <= '0;
         end
      end else if (bit_cnt == CW'(clks_per_bit - 1)) begin
         bit_cnt <= '0;
         frame   <= {1'b1, frame[9:1]};
         if (bit_idx == 4'd9) begin
            busy <= 1'b0;   // End of stop bit
         end else begin
            bit_idx <= bit_idx + 4'd1;
         end
      end else begin
         bit_cnt <= bit_cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: hw/spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master import boot_pkg::*; #(
   parameter int sck_half = DEF_SCK_HALF
) (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       go,
   input  logic [7:0] tx,
   output logic       busy,
   output logic       done_pulse,
   output logic [7:0] rx,
   output logic       sck,
   output logic       mosi,
   input  logic       miso
);

   localparam int HW = (sck_half > 1) ? $clog2(sck_half) : 1;

   logic [HW-1:0] half_cnt;
   logic [3:0]    edge_cnt;   // Counts SCK edges, 16 per byte
   logic [7:0]    shreg;
   logic          miso_bit;   // Held from the rising edge
   logic          half_end;

   assign half_end = (half_cnt == HW'(sck_half - 1));

   // Mode 0, MSB first, line parked low between bytes
   assign mosi = busy & shreg[7];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy       <= 1'b0;
         done_pulse <= 1'b0;
         sck        <= 1'b0;
         half_cnt   <= '0;
         edge_cnt   <= '0;
      end else begin
         done_pulse <= 1'b0;
         if (!busy) begin
            if (go) begin
               busy     <= 1'b1;
               half_cnt <= '0;
               edge_cnt <= '0;
            end
         end else if (half_end) begin
            half_cnt <= '0;
            sck      <= ~sck;
            edge_cnt <= edge_cnt + 4'd1;
            // Eighth falling edge closes the byte with SCK back low
            if (sck && edge_cnt == 4'd15) begin
               busy       <= 1'b0;
               done_pulse <= 1'b1;
            end
         end else begin
            half_cnt <= half_cnt + 1'b1;
         end
      end
   end

   // Sample on the rise, shift on the fall so mosi is stable while SCK is high
   always_ff @(posedge clk) begin
      if (!busy && go) begin
         shreg <= tx;
      end else if (busy && half_end) begin
         if (!sck) begin
            miso_bit <= miso;
         end else begin
            shreg <= {shreg[6:0], miso_bit};
            if (edge_cnt == 4'd15)
               rx <= {shreg[6:0], miso_bit};   // Valid with done_pulse
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/boot_pkg.sv
`default_nettype none

package boot_pkg;

   // Number of address bytes after the opcode, sent MSB first
   localparam int ADDR_BYTES = 3;

   // Standard SPI flash slow read
   localparam logic [7:0] FLASH_READ_CMD = 8'h03;

   // Default timing, overridden from the top level
   localparam int DEF_SCK_HALF     = 2;   // clk cycles per SCK half period
   localparam int DEF_CLKS_PER_BIT = 16;  // clk cycles per UART bit

   // Boot read request from the host
   typedef struct packed {
      logic [8*ADDR_BYTES-1:0] addr;  // Start address in flash
      logic [7:0]              len;   // Byte count, 0 means 256
   } boot_req_t;

endpackage

`default_nettype wire
